// File: fpu_config.svh
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// binary32 field widths
`define FPU_EXP_W    8
`define FPU_FRAC_W   23
`define FPU_BIAS     127

// canonical quiet NaN
`define FPU_QNAN     32'h7FC00000

// stages from input to output register
`define FPU_LATENCY  3

`endif

// File: fpu_pkg.sv
package fpu_pkg;

   // function codes on funct7
   typedef enum logic [6:0] {
      FPU_ADD = 7'b0000000,
      FPU_SUB = 7'b0000100,
      FPU_MUL = 7'b0001000
   } fpu_op_e;

   // operand classes after unpacking, subnormals land in zero
   typedef enum logic [1:0] {
      CLS_ZERO   = 2'd0,
      CLS_NORMAL = 2'd1,
      CLS_INF    = 2'd2,
      CLS_NAN    = 2'd3
   } fpu_class_e;

   // flag port layout, msb first
   typedef struct packed {
      logic nv;   // invalid
      logic dz;   // divide by zero, no divider so always low
      logic of;   // overflow
      logic uf;   // underflow
      logic nx;   // inexact
   } fpu_flags_t;

endpackage

// File: fpu_if.sv
`timescale 1ns/100ps
`include "fpu_config.svh"

// unpack/align stage to mantissa stage
interface align_if;
   logic                             valid;
   fpu_pkg::fpu_op_e                 op;
   logic                             sign;     // sign of the larger operand or product
   logic                             eff_sub;  // magnitudes subtract
   logic signed [`FPU_EXP_W+1:0]     exp;
   logic [`FPU_FRAC_W+3:0]           man_a;    // larger operand, grs zero
   logic [`FPU_FRAC_W+3:0]           man_b;    // aligned smaller operand with grs
   logic                             special;
   logic [31:0]                      spec_result;
   fpu_pkg::fpu_flags_t              spec_flags;

   modport src (
      output valid, op, sign, eff_sub, exp, man_a, man_b,
             special, spec_result, spec_flags
   );

   modport dst (
      input  valid, op, sign, eff_sub, exp, man_a, man_b,
             special, spec_result, spec_flags
   );
endinterface

// mantissa stage to round/pack stage
interface arith_if;
   logic                             valid;
   logic                             sign;
   logic signed [`FPU_EXP_W+1:0]     exp;
   logic [2*`FPU_FRAC_W+1:0]         man;      // bit 46 weighs 2^exp
   logic                             sticky;
   logic                             special;
   logic [31:0]                      spec_result;
   fpu_pkg::fpu_flags_t              spec_flags;

   modport src (
      output valid, sign, exp, man, sticky,
             special, spec_result, spec_flags
   );

   modport dst (
      input  valid, sign, exp, man, sticky,
             special, spec_result, spec_flags
   );
endinterface

// File: fpu_unpack_align.sv
`timescale 1ns/100ps
`include "fpu_config.svh"

module fpu_unpack_align (
   input  logic             clk,
   input  logic             nrst,
   input  logic             in_valid,
   input  fpu_pkg::fpu_op_e op,
   input  logic [31:0]      a,
   input  logic [31:0]      b,
   align_if.src             out
);
   localparam int EW = `FPU_EXP_W;
   localparam int FW = `FPU_FRAC_W;

   fpu_pkg::fpu_class_e cls_a, cls_b;
   logic                sign_a, sign_b;   // sign_b flipped for subtract
   logic [FW:0]         man_a, man_b;
   logic [30:0]         mag_a, mag_b;
   logic                is_mul, is_addsub;
   logic                swap;
   logic [EW-1:0]       exp_l, exp_s, diff;
   logic [FW:0]         man_l, man_s;
   logic [4:0]          shamt;
   logic [FW+27:0]      wide;
   logic                sign_inf;
   logic                special;
   logic [31:0]         spec_result;
   fpu_pkg::fpu_flags_t spec_flags;
   logic                sign_res;
   logic signed [EW+1:0] exp_res;
   logic [FW+3:0]       op_a, op_b;

   function automatic fpu_pkg::fpu_class_e classify(input logic [31:0] x);
      if (x[30:FW] == '0)
         return fpu_pkg::CLS_ZERO;   // subnormals read as zero
      else if (x[30:FW] != '1)
         return fpu_pkg::CLS_NORMAL;
      else if (x[FW-1:0] == '0)
         return fpu_pkg::CLS_INF;
      else
         return fpu_pkg::CLS_NAN;
   endfunction

   always_comb begin
      is_mul    = (op == fpu_pkg::FPU_MUL);
      is_addsub = (op == fpu_pkg::FPU_ADD) || (op == fpu_pkg::FPU_SUB);
      cls_a     = classify(a);
      cls_b     = classify(b);
      sign_a    = a[31];
      sign_b    = b[31] ^ (op == fpu_pkg::FPU_SUB);
      man_a     = (cls_a == fpu_pkg::CLS_NORMAL) ? {1'b1, a[FW-1:0]} : '0;
      man_b     = (cls_b == fpu_pkg::CLS_NORMAL) ? {1'b1, b[FW-1:0]} : '0;
      mag_a     = (cls_a == fpu_pkg::CLS_ZERO) ? '0 : a[30:0];
      mag_b     = (cls_b == fpu_pkg::CLS_ZERO) ? '0 : b[30:0];
   end

   // special cases, first match wins
   always_comb begin
      sign_inf    = is_mul ? (sign_a ^ sign_b) :
                    ((cls_a == fpu_pkg::CLS_INF) ? sign_a : sign_b);
      special     = 1'b1;
      spec_result = `FPU_QNAN;
      spec_flags  = '0;
      if (!is_mul && !is_addsub) begin
         spec_flags.nv = 1'b1;   // undefined funct7
      end else if (cls_a == fpu_pkg::CLS_NAN || cls_b == fpu_pkg::CLS_NAN) begin
         // quiet bit low means signaling
         spec_flags.nv = (cls_a == fpu_pkg::CLS_NAN && !a[FW-1]) ||
                         (cls_b == fpu_pkg::CLS_NAN && !b[FW-1]);
      end else if (is_addsub && cls_a == fpu_pkg::CLS_INF &&
                   cls_b == fpu_pkg::CLS_INF && sign_a != sign_b) begin
         spec_flags.nv = 1'b1;   // inf - inf
      end else if (is_mul && ((cls_a == fpu_pkg::CLS_INF && cls_b == fpu_pkg::CLS_ZERO) ||
                              (cls_a == fpu_pkg::CLS_ZERO && cls_b == fpu_pkg::CLS_INF))) begin
         spec_flags.nv = 1'b1;   // 0 * inf
      end else if (cls_a == fpu_pkg::CLS_INF || cls_b == fpu_pkg::CLS_INF) begin
         spec_result = {sign_inf, {EW{1'b1}}, {FW{1'b0}}};
      end else if (is_mul && (cls_a == fpu_pkg::CLS_ZERO || cls_b == fpu_pkg::CLS_ZERO)) begin
         spec_result = {sign_a ^ sign_b, 31'b0};
      end else begin
         special = 1'b0;
      end
   end

   // order by magnitude and align the smaller operand
   always_comb begin
      swap  = (mag_b > mag_a);
      exp_l = swap ? mag_b[30:FW] : mag_a[30:FW];
      exp_s = swap ? mag_a[30:FW] : mag_b[30:FW];
      man_l = swap ? man_b : man_a;
      man_s = swap ? man_a : man_b;
      diff  = exp_l - exp_s;
      shamt = (diff > 8'd27) ? 5'd27 : diff[4:0];   // beyond 27 all goes to sticky
      wide  = {man_s, 27'b0} >> shamt;
      if (is_mul) begin
         sign_res = sign_a ^ sign_b;
         exp_res  = $signed({2'b00, a[30:FW]}) + $signed({2'b00, b[30:FW]})
                    - $signed((EW+2)'(`FPU_BIAS));
         op_a     = {man_a, 3'b000};
         op_b     = {man_b, 3'b000};
      end else begin
         sign_res = swap ? sign_b : sign_a;
         exp_res  = $signed({2'b00, exp_l});
         op_a     = {man_l, 3'b000};
         op_b     = {wide[FW+27:25], |wide[24:0]};   // g, r, then sticky
      end
   end

   always_ff @(posedge clk, negedge nrst) begin
      if (!nrst)
         out.valid <= 1'b0;
      else
         out.valid <= in_valid;
   end

   always_ff @(posedge clk) begin
      out.op          <= op;
      out.sign        <= sign_res;
      out.eff_sub     <= is_addsub && (sign_a != sign_b);
      out.exp         <= exp_res;
      out.man_a       <= op_a;
      out.man_b       <= op_b;
      out.special     <= special;
      out.spec_result <= spec_result;
      out.spec_flags  <= spec_flags;
   end

endmodule

// File: fpu_mantissa_op.sv
`timescale 1ns/100ps
`include "fpu_config.svh"

module fpu_mantissa_op (
   input  logic clk,
   input  logic nrst,
   align_if.dst in,
   arith_if.src out
);
   localparam int FW = `FPU_FRAC_W;
   localparam int MW = 2 * (FW + 1);   // full product width

   logic          is_mul;
   logic [FW+4:0] sum;      // one carry bit over the aligned width
   logic [MW-1:0] prod;
   logic [MW-1:0] raw;
   logic          sign_nxt;
   logic          sticky_nxt;

   always_comb begin
      is_mul = (in.op == fpu_pkg::FPU_MUL);

      // larger magnitude sits in man_a, so no negative difference
      if (in.eff_sub)
         sum = {1'b0, in.man_a} - {1'b0, in.man_b};
      else
         sum = {1'b0, in.man_a} + {1'b0, in.man_b};

      prod = in.man_a[FW+3:3] * in.man_b[FW+3:3];

      // both paths put the 2^exp weight at bit MW-2
      if (is_mul) begin
         raw        = prod;
         sticky_nxt = 1'b0;   // product is exact
      end else begin
         raw        = {sum, {(MW-FW-5){1'b0}}};
         sticky_nxt = in.man_b[0];
      end

      // exact cancellation gives +0
      if (!is_mul && in.eff_sub && sum == '0)
         sign_nxt = 1'b0;
      else
         sign_nxt = in.sign;
   end

   always_ff @(posedge clk, negedge nrst) begin
      if (!nrst)
         out.valid <= 1'b0;
      else
         out.valid <= in.valid;
   end

   always_ff @(posedge clk) begin
      out.sign        <= sign_nxt;
      out.exp         <= in.exp;
      out.man         <= raw;
      out.sticky      <= sticky_nxt;
      out.special     <= in.special;
      out.spec_result <= in.spec_result;
      out.spec_flags  <= in.spec_flags;
   end

endmodule

// File: fpu_round_pack.sv
`timescale 1ns/100ps
`include "fpu_config.svh"

module fpu_round_pack (
   input  logic                clk,
   input  logic                nrst,
   arith_if.dst                in,
   output logic                out_valid,
   output logic [31:0]         result,
   output fpu_pkg::fpu_flags_t flags
);
   localparam int EW   = `FPU_EXP_W;
   localparam int FW   = `FPU_FRAC_W;
   localparam int MW   = 2 * (FW + 1);
   localparam int EMAX = (1 << EW) - 2;   // largest biased normal exponent

   logic [5:0]           lz;
   logic [MW-1:0]        norm;
   logic                 guard;
   logic                 sticky;
   logic                 round_up;
   logic [FW+1:0]        man_r;   // rounded mantissa plus carry
   logic [FW-1:0]        frac;
   logic signed [EW+1:0] exp_n;
   logic signed [EW+1:0] exp_r;
   logic [31:0]          res_nxt;
   fpu_pkg::fpu_flags_t  flags_nxt;

   // leading one, lowest index first so the top one wins
   always_comb begin
      lz = '0;
      for (int i = 0; i < MW; i++) begin
         if (in.man[i])
            lz = 6'(MW - 1 - i);
      end
   end

   always_comb begin
      norm     = in.man << lz;
      guard    = norm[MW-FW-2];
      sticky   = |norm[MW-FW-3:0] | in.sticky;
      round_up = guard & (sticky | norm[MW-FW-1]);   // ties to even
      man_r    = {1'b0, norm[MW-1:MW-FW-1]} + (FW+2)'(round_up);
      frac     = man_r[FW+1] ? man_r[FW:1] : man_r[FW-1:0];
      exp_n    = in.exp + $signed((EW+2)'(1)) - $signed({4'b0000, lz});
      exp_r    = exp_n + $signed({{(EW+1){1'b0}}, man_r[FW+1]});

      flags_nxt = '0;
      if (in.special) begin
         res_nxt   = in.spec_result;
         flags_nxt = in.spec_flags;
      end else if (in.man == '0) begin
         res_nxt = {in.sign, 31'b0};   // exact zero
      end else if (exp_r > EMAX) begin
         res_nxt      = {in.sign, {EW{1'b1}}, {FW{1'b0}}};
         flags_nxt.of = 1'b1;
         flags_nxt.nx = 1'b1;
      end else if (exp_r < 1) begin
         res_nxt      = {in.sign, 31'b0};   // flush to zero
         flags_nxt.uf = 1'b1;
         flags_nxt.nx = 1'b1;
      end else begin
         res_nxt      = {in.sign, exp_r[EW-1:0], frac};
         flags_nxt.nx = guard | sticky;
      end
   end

   always_ff @(posedge clk, negedge nrst) begin
      if (!nrst) begin
         out_valid <= 1'b0;
         result    <= '0;
         flags     <= '0;
      end else begin
         out_valid <= in.valid;
         result    <= res_nxt;
         flags     <= flags_nxt;
      end
   end

endmodule

// File: fpu_top.sv
`timescale 1ns/100ps

module fpu_top (
   input  logic        clk,
   input  logic        nrst,
   input  logic        in_valid,
   input  logic [6:0]  funct7,
   input  logic [31:0] floating_point1,
   input  logic [31:0] floating_point2,
   output logic        out_valid,
   output logic [31:0] floating_point_out,
   output logic [4:0]  flags
);

   align_if u_align_if ();
   arith_if u_arith_if ();

   // stage one, unpack and align
   fpu_unpack_align u_unpack_align (
      .clk      (clk),
      .nrst     (nrst),
      .in_valid (in_valid),
      .op       (fpu_pkg::fpu_op_e'(funct7)),   // unknown codes flagged in stage one
      .a        (floating_point1),
      .b        (floating_point2),
      .out      (u_align_if.src)
   );

   // stage two, add/sub or multiply
   fpu_mantissa_op u_mantissa_op (
      .clk  (clk),
      .nrst (nrst),
      .in   (u_align_if.dst),
      .out  (u_arith_if.src)
   );

   // stage three, normalize, round, pack
   fpu_round_pack u_round_pack (
      .clk       (clk),
      .nrst      (nrst),
      .in        (u_arith_if.dst),
      .out_valid (out_valid),
      .result    (floating_point_out),
      .flags     (flags)
   );

endmodule

// File: fpu_props.sv
`timescale 1ns/100ps
`include "fpu_config.svh"

module fpu_props (
   input logic                clk,
   input logic                nrst,
   input logic                in_valid,
   input logic                out_valid,
   input logic [31:0]         floating_point_out,
   input fpu_pkg::fpu_flags_t flags
);
   logic res_is_nan;
   int   n_fail = 0;   // failed assertion count

   assign res_is_nan = (floating_point_out[30:23] == 8'hFF) && (floating_point_out[22:0] != '0);

   // fixed depth, no stall
   a_latency: assert property (@(posedge clk) disable iff (!nrst)
      out_valid == $past(in_valid, `FPU_LATENCY))
      else begin
         $error("out_valid does not follow in_valid by the pipeline depth");
         n_fail++;
      end

   a_reset_quiet: assert property (@(posedge clk) !nrst |-> !out_valid)
      else begin
         $error("out_valid high during reset");
         n_fail++;
      end

   // no divider in this unit
   a_no_dz: assert property (@(posedge clk) disable iff (!nrst) out_valid |-> !flags.dz)
      else begin
         $error("divide-by-zero flag set");
         n_fail++;
      end

   a_canon_nan: assert property (@(posedge clk) disable iff (!nrst)
      (out_valid && res_is_nan) |-> floating_point_out == `FPU_QNAN)
      else begin
         $error("NaN result is not the canonical encoding");
         n_fail++;
      end

endmodule

bind fpu_top fpu_props u_props (
   .clk                (clk),
   .nrst               (nrst),
   .in_valid           (in_valid),
   .out_valid          (out_valid),
   .floating_point_out (floating_point_out),
   .flags              (flags)
);

// File: fpu_tb.sv
`timescale 1ns/100ps
`include "fpu_config.svh"

module fpu_tb;
   localparam int N_RAND     = 400;
   localparam int N_DIR      = 16;
   localparam int MAX_CYCLES = 2 * (N_RAND + N_DIR) + 50;

   logic        clk;
   logic        nrst;
   logic        in_valid;
   logic [6:0]  funct7;
   logic [31:0] floating_point1;
   logic [31:0] floating_point2;
   logic        out_valid;
   logic [31:0] floating_point_out;
   logic [4:0]  flags;

   logic [31:0]         res_q[$];   // expected results, oldest first
   fpu_pkg::fpu_flags_t flag_q[$];
   int                  cyc_q[$];   // cycle the result must show up
   logic [70:0]         dir_vec [N_DIR];
   int                  cycle    = 0;
   int                  n_checks = 0;
   int                  n_errors = 0;

   fpu_top UUT (
      .clk                (clk),
      .nrst               (nrst),
      .in_valid           (in_valid),
      .funct7             (funct7),
      .floating_point1    (floating_point1),
      .floating_point2    (floating_point2),
      .out_valid          (out_valid),
      .floating_point_out (floating_point_out),
      .flags              (flags)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES) begin
         $display("Timeout: %0d results still outstanding after %0d cycles", res_q.size(), cycle);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
      n_checks++;
      if (got !== want) begin
         n_errors++;
         $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, want);
      end
   endtask

   function automatic logic [31:0] rand_normal();
      logic [7:0] e;
      e = 8'(64 + $urandom % 127);   // keeps sums and products in range
      return {1'($urandom), e, 23'($urandom)};
   endfunction

   function automatic real float_to_real(input logic [31:0] f, input logic s);
      logic [10:0] de;
      if (f[30:23] == 8'h00)
         return 0.0;   // subnormal reads as zero
      de = {3'b000, f[30:23]} + 11'd896;
      return $bitstoreal({s, de, f[22:0], 29'b0});
   endfunction

   // nearest even from a nonzero double, extra marks bits lost below the double
   task automatic round_to_single(input real r, input logic extra, output logic [31:0] res,
                                  output fpu_pkg::fpu_flags_t fl);
      logic [63:0] d;
      logic [52:0] m53;
      logic [24:0] m;
      logic        g, st;
      int          e32;
      d   = $realtobits(r);
      m53 = {1'b1, d[51:0]};
      g   = m53[28];
      st  = |m53[27:0];
      m   = {1'b0, m53[52:29]} + 25'(g & (st | m53[29]));
      e32 = d[62:52];
      e32 = e32 - 896 + (m[24] ? 1 : 0);   // carry out of rounding bumps the exponent
      fl  = '0;
      if (e32 > 254) begin
         res   = {d[63], 8'hFF, 23'b0};
         fl.of = 1'b1;
         fl.nx = 1'b1;
      end else if (e32 < 1) begin
         res   = {d[63], 31'b0};
         fl.uf = 1'b1;
         fl.nx = 1'b1;
      end else begin
         res   = {d[63], e32[7:0], m[22:0]};
         fl.nx = g | st | extra;
      end
   endtask

   task automatic model_op(input logic [6:0] op, input logic [31:0] a, input logic [31:0] b,
                           output logic [31:0] res, output fpu_pkg::fpu_flags_t fl);
      logic is_mul, is_as, sa, sb;
      logic a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
      real  x, y, s, bb, e;
      is_mul = (op == fpu_pkg::FPU_MUL);
      is_as  = (op == fpu_pkg::FPU_ADD) || (op == fpu_pkg::FPU_SUB);
      sa     = a[31];
      sb     = b[31] ^ (op == fpu_pkg::FPU_SUB);
      a_zero = (a[30:23] == 8'h00);
      b_zero = (b[30:23] == 8'h00);
      a_inf  = (a[30:23] == 8'hFF) && (a[22:0] == '0);
      b_inf  = (b[30:23] == 8'hFF) && (b[22:0] == '0);
      a_nan  = (a[30:23] == 8'hFF) && (a[22:0] != '0);
      b_nan  = (b[30:23] == 8'hFF) && (b[22:0] != '0);
      res    = `FPU_QNAN;
      fl     = '0;
      if (!is_mul && !is_as)
         fl.nv = 1'b1;
      else if (a_nan || b_nan)
         fl.nv = (a_nan && !a[22]) || (b_nan && !b[22]);   // signaling NaN in
      else if (is_as && a_inf && b_inf && sa != sb)
         fl.nv = 1'b1;
      else if (is_mul && ((a_inf && b_zero) || (a_zero && b_inf)))
         fl.nv = 1'b1;
      else if (a_inf || b_inf)
         res = {is_mul ? (sa ^ sb) : (a_inf ? sa : sb), 8'hFF, 23'b0};
      else if (is_mul && (a_zero || b_zero))
         res = {sa ^ sb, 31'b0};
      else begin
         x = float_to_real(a, sa);
         y = float_to_real(b, sb);
         if (is_mul) begin
            round_to_single(x * y, 1'b0, res, fl);   // 48-bit product fits a double
         end else begin
            s = x + y;
            if (s == 0.0) begin
               res = {sa & sb, 31'b0};   // -0 only when both addends negative
            end else begin
               bb = s - x;   // two-sum error term
               e  = (x - (s - bb)) + (y - bb);
               round_to_single(s, e != 0.0, res, fl);
            end
         end
      end
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #1;
      in_valid        = 1'b0;
      funct7          = 7'($urandom);
      floating_point1 = $urandom;
      floating_point2 = $urandom;
   endtask

   task automatic send_op(input logic [6:0] op, input logic [31:0] a, input logic [31:0] b);
      logic [31:0]         res;
      fpu_pkg::fpu_flags_t fl;
      while ($urandom % 4 == 0)
         idle_cycle();
      @(posedge clk);
      #1;
      in_valid        = 1'b1;
      funct7          = op;
      floating_point1 = a;
      floating_point2 = b;
      model_op(op, a, b, res, fl);
      res_q.push_back(res);
      flag_q.push_back(fl);
      cyc_q.push_back(cycle + `FPU_LATENCY);
   endtask

   // outputs settle well before the falling edge
   always @(negedge clk) begin
      if (nrst && out_valid) begin
         if (res_q.size() == 0) begin
            n_errors++;
            $display("Error at %0t: a result came out with no operation outstanding", $time);
         end else begin
            check_value("result", floating_point_out, res_q.pop_front());
            check_value("flags", flags, flag_q.pop_front());
            check_value("exit cycle", cycle, cyc_q.pop_front());
         end
      end
   end

   initial begin
      logic [6:0]  op;
      logic [31:0] a, b;
      int          sel;
      int          n_assert;
      nrst            = 1'b0;
      in_valid        = 1'b0;
      funct7          = '0;
      floating_point1 = '0;
      floating_point2 = '0;
      sel             = $urandom(40);
      dir_vec = '{
         {fpu_pkg::FPU_SUB, 32'h7F800000, 32'h7F800000},   // inf - inf
         {fpu_pkg::FPU_ADD, 32'h7F800000, 32'hFF800000},
         {fpu_pkg::FPU_MUL, 32'h00000000, 32'hFF800000},   // 0 * inf
         {fpu_pkg::FPU_ADD, 32'h7FC12345, 32'h3F800000},   // quiet NaN
         {fpu_pkg::FPU_MUL, 32'h7F800001, 32'h3F800000},   // signaling NaN
         {fpu_pkg::FPU_ADD, 32'h7F800000, 32'hC2C80000},
         {fpu_pkg::FPU_SUB, 32'h3F800000, 32'h7F800000},
         {fpu_pkg::FPU_MUL, 32'h7F000000, 32'h7F000000},   // overflow
         {fpu_pkg::FPU_MUL, 32'hFF000000, 32'h7E800000},
         {fpu_pkg::FPU_MUL, 32'h00800000, 32'h00800000},   // underflow
         {fpu_pkg::FPU_MUL, 32'h80800000, 32'h0C000000},
         {fpu_pkg::FPU_ADD, 32'h00000001, 32'h3F800000},   // subnormal as zero
         {fpu_pkg::FPU_MUL, 32'h807FFFFF, 32'h40000000},
         {fpu_pkg::FPU_SUB, 32'h40490FDB, 32'h40490FDB},   // x - x
         {fpu_pkg::FPU_ADD, 32'h80000000, 32'h80000000},   // -0 + -0
         {7'h7F,            32'h3F800000, 32'h3F800000}    // undefined funct7
      };

      repeat (4) @(posedge clk);
      #1 nrst = 1'b1;

      for (int i = 0; i < N_RAND; i++) begin
         sel = $urandom % 3;
         op  = (sel == 0) ? fpu_pkg::FPU_ADD : (sel == 1) ? fpu_pkg::FPU_SUB : fpu_pkg::FPU_MUL;
         a   = rand_normal();
         b   = rand_normal();
         if (op != fpu_pkg::FPU_MUL && $urandom % 8 == 0)
            b = {a[31] ^ (op == fpu_pkg::FPU_ADD), a[30:8], 8'($urandom)};   // near cancellation
         send_op(op, a, b);
      end
      for (int i = 0; i < N_DIR; i++)
         send_op(dir_vec[i][70:64], dir_vec[i][63:32], dir_vec[i][31:0]);
      idle_cycle();

      while (res_q.size() != 0)
         @(posedge clk);
      repeat (4) @(posedge clk);   // catch stray results
      n_assert = UUT.u_props.n_fail;
      $display("checks: %0d, errors: %0d, assertion failures: %0d", n_checks, n_errors, n_assert);
      if (n_errors == 0 && n_assert == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: fpu_top.f
+incdir+.
fpu_pkg.sv
fpu_if.sv
fpu_unpack_align.sv
fpu_mantissa_op.sv
fpu_round_pack.sv
fpu_top.sv
fpu_props.sv
fpu_tb.sv
